// ==== logic/pkt_guard_pkg.sv ====
// ----------------------------------------
// shared types and sizing helpers for the
// ingress packet guard, imported by the RTL
// and by the verification files
// ----------------------------------------
`default_nettype none

package pkt_guard_pkg;

   // ----------------------------------------
   // state and cause encodings
   // ----------------------------------------

   // ingress packet tracking
   // ING_SOP next word opens a packet, ING_BODY kept packet in progress,
   // ING_DROP overflowed packet being skipped up to its last word
   typedef enum logic [1:0] {
      ING_SOP  = 2'd0,
      ING_BODY = 2'd1,
      ING_DROP = 2'd2
   } ing_state_t;

   // reason reported alongside each drop pulse
   typedef enum logic [1:0] {
      DROP_NONE = 2'd0,
      DROP_OVFL = 2'd1,
      DROP_ERR  = 2'd2
   } drop_cause_t;

   // ----------------------------------------
   // width helpers
   // ----------------------------------------

   // words needed for one maximum length packet, rounded up
   function automatic int max_pkt_words(input int max_pkt_len, input int data_byte_wid);
      return (max_pkt_len + data_byte_wid - 1) / data_byte_wid;
   endfunction

   // address bits for a buffer of three maximum packets
   function automatic int buf_addr_wid(input int max_pkt_len, input int data_byte_wid);
      return $clog2(3 * max_pkt_words(max_pkt_len, data_byte_wid));
   endfunction

endpackage

`default_nettype wire

// ==== logic/pkt_ingress.sv ====
// ----------------------------------------
// ingress side of the packet guard: writes every
// word of a kept packet and winds the write pointer
// back when a packet is dropped for overflow or error
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pkt_ingress #(
   parameter int DATA_BYTE_WID = 8,
   parameter int MAX_PKT_LEN   = 64,
   parameter int USER_WID      = 4,
   parameter bit DROP_ERRORED  = 1'b0,
   localparam int ADDR_WID     = pkt_guard_pkg::buf_addr_wid(MAX_PKT_LEN, DATA_BYTE_WID)
) (
   input  logic                       axi4s_in,
   input  logic                       arst_n,
   input  logic                       in_valid,
   input  logic [DATA_BYTE_WID*8-1:0] in_data,
   input  logic [DATA_BYTE_WID-1:0]   in_keep,
   input  logic                       in_last,
   input  logic [USER_WID-1:0]        in_user,
   input  logic [ADDR_WID:0]          rd_ptr,
   output logic                       wr_en,
   output logic [ADDR_WID-1:0]        wr_addr,
   output logic [DATA_BYTE_WID*8-1:0] wr_data,
   output logic [DATA_BYTE_WID-1:0]   wr_keep,
   output logic                       wr_last,
   output logic [USER_WID-1:0]        wr_user,
   output logic [ADDR_WID:0]          wr_ptr,
   output logic [ADDR_WID:0]          sop_ptr,
   output logic                       drop_pulse,
   output pkt_guard_pkg::drop_cause_t drop_cause
);
   import pkt_guard_pkg::*;

   // a start word is refused once less than one max packet of room is left
   localparam int PKT_WORDS = max_pkt_words(MAX_PKT_LEN, DATA_BYTE_WID);
   localparam int OVFL_LVL  = 2 * PKT_WORDS;

   ing_state_t        state_q, state_d;
   logic [ADDR_WID:0] wr_ptr_d;
   logic [ADDR_WID:0] sop_ptr_d;
   logic [ADDR_WID:0] fill_lvl;
   logic              ovfl_start;
   logic              err_last;

   // wrap bit makes the difference the true fill level
   assign fill_lvl   = wr_ptr - rd_ptr;
   // packet start is implied by the state, the bus has no sop flag
   assign ovfl_start = in_valid && (state_q == ING_SOP) && (int'(fill_lvl) > OVFL_LVL);
   // error flag only counts on the last word
   assign err_last   = DROP_ERRORED && in_last && in_user[0];

   // ----------------------------------------
   // memory write port
   // ----------------------------------------

   // skipped packets never touch the memory
   assign wr_en   = in_valid && (state_q != ING_DROP) && !ovfl_start;
   assign wr_addr = wr_ptr[ADDR_WID-1:0];
   assign wr_data = in_data;
   assign wr_keep = in_keep;
   assign wr_last = in_last;
   assign wr_user = in_user;

   // ----------------------------------------
   // packet FSM and pointer update
   // ----------------------------------------
   always_comb begin
      state_d    = state_q;
      wr_ptr_d   = wr_ptr;
      sop_ptr_d  = sop_ptr;
      drop_pulse = 1'b0;
      drop_cause = DROP_NONE;
      if (in_valid) begin
         case (state_q)
            ING_SOP, ING_BODY: begin
               if (ovfl_start) begin
                  // single word packet is over at once
                  if (in_last) begin
                     drop_pulse = 1'b1;
                     drop_cause = DROP_OVFL;
                  end else begin
                     state_d = ING_DROP;
                  end
               end else if (in_last) begin
                  state_d = ING_SOP;
                  if (err_last) begin
                     // forget the whole packet
                     wr_ptr_d   = sop_ptr;
                     drop_pulse = 1'b1;
                     drop_cause = DROP_ERR;
                  end else begin
                     // packet complete, release it to egress
                     wr_ptr_d  = wr_ptr + 1'b1;
                     sop_ptr_d = wr_ptr + 1'b1;
                  end
               end else begin
                  wr_ptr_d = wr_ptr + 1'b1;
                  state_d  = ING_BODY;
               end
            end
            ING_DROP: begin
               // report once the skipped packet has ended
               if (in_last) begin
                  state_d    = ING_SOP;
                  drop_pulse = 1'b1;
                  drop_cause = DROP_OVFL;
               end
            end
            default: state_d = ING_SOP;
         endcase
      end
   end

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ING_SOP;
         wr_ptr  <= '0;
         sop_ptr <= '0;
      end else begin
         state_q <= state_d;
         wr_ptr  <= wr_ptr_d;
         sop_ptr <= sop_ptr_d;
      end
   end

endmodule

`default_nettype wire

// ==== logic/pkt_ram.sv ====
// ----------------------------------------
// word store of the packet buffer, one write
// and one registered read port
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pkt_ram #(
   parameter int DATA_BYTE_WID = 8,
   parameter int MAX_PKT_LEN   = 64,
   parameter int USER_WID      = 4,
   localparam int ADDR_WID     = pkt_guard_pkg::buf_addr_wid(MAX_PKT_LEN, DATA_BYTE_WID)
) (
   input  logic                       axi4s_in,
   input  logic                       wr_en,
   input  logic [ADDR_WID-1:0]        wr_addr,
   input  logic [DATA_BYTE_WID*8-1:0] wr_data,
   input  logic [DATA_BYTE_WID-1:0]   wr_keep,
   input  logic                       wr_last,
   input  logic [USER_WID-1:0]        wr_user,
   input  logic                       rd_en,
   input  logic [ADDR_WID-1:0]        rd_addr,
   output logic [DATA_BYTE_WID*8-1:0] rd_data,
   output logic [DATA_BYTE_WID-1:0]   rd_keep,
   output logic                       rd_last,
   output logic [USER_WID-1:0]        rd_user
);

   // stored word is {last, user, keep, data}
   localparam int WORD_WID = 1 + USER_WID + DATA_BYTE_WID + DATA_BYTE_WID * 8;
   localparam int DEPTH    = 2 ** ADDR_WID;

   logic [WORD_WID-1:0] mem [DEPTH];
   logic [WORD_WID-1:0] rd_word_q;

   always_ff @(posedge axi4s_in) begin
      if (wr_en) begin
         mem[wr_addr] <= {wr_last, wr_user, wr_keep, wr_data};
      end
      // output holds while no read is issued
      if (rd_en) begin
         rd_word_q <= mem[rd_addr];
      end
   end

   assign {rd_last, rd_user, rd_keep, rd_data} = rd_word_q;

endmodule

`default_nettype wire

// ==== logic/pkt_egress.sv ====
// ----------------------------------------
// egress side of the packet guard: reads only
// finished packets and spends one credit per word,
// output word is registered after the memory read
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pkt_egress #(
   parameter int DATA_BYTE_WID = 8,
   parameter int MAX_PKT_LEN   = 64,
   parameter int USER_WID      = 4,
   parameter int CREDIT_MAX    = 4,
   localparam int ADDR_WID     = pkt_guard_pkg::buf_addr_wid(MAX_PKT_LEN, DATA_BYTE_WID)
) (
   input  logic                       axi4s_in,
   input  logic                       arst_n,
   input  logic [ADDR_WID:0]          sop_ptr,
   input  logic                       out_credit,
   input  logic [DATA_BYTE_WID*8-1:0] rd_data,
   input  logic [DATA_BYTE_WID-1:0]   rd_keep,
   input  logic                       rd_last,
   input  logic [USER_WID-1:0]        rd_user,
   output logic                       rd_en,
   output logic [ADDR_WID-1:0]        rd_addr,
   output logic [ADDR_WID:0]          rd_ptr,
   output logic                       out_valid,
   output logic [DATA_BYTE_WID*8-1:0] out_data,
   output logic [DATA_BYTE_WID-1:0]   out_keep,
   output logic                       out_last,
   output logic [USER_WID-1:0]        out_user
);

   localparam int CNT_WID = $clog2(CREDIT_MAX + 1);

   logic [CNT_WID-1:0] credit_q;
   logic               pkt_avail;
   logic               rd_vld_q;

   // ----------------------------------------
   // read request
   // ----------------------------------------

   // sop_ptr only moves past complete packets, so anything below it may go
   assign pkt_avail = (rd_ptr != sop_ptr);
   // credit is taken at the read, covering words still in the pipe
   assign rd_en     = pkt_avail && (credit_q != '0);
   assign rd_addr   = rd_ptr[ADDR_WID-1:0];

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         rd_ptr   <= '0;
         credit_q <= CNT_WID'(CREDIT_MAX);
      end else begin
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // a return and a spend in one cycle cancel out
         case ({out_credit, rd_en})
            2'b10:   credit_q <= credit_q + 1'b1;
            2'b01:   credit_q <= credit_q - 1'b1;
            default: credit_q <= credit_q;
         endcase
      end
   end

   // ----------------------------------------
   // output stage
   // ----------------------------------------

   // rd_vld_q marks the memory word, out_valid the word on the bus
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         rd_vld_q  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         rd_vld_q  <= rd_en;
         out_valid <= rd_vld_q;
      end
   end

   // payload only loads with a fresh memory word
   always_ff @(posedge axi4s_in) begin
      if (rd_vld_q) begin
         out_data <= rd_data;
         out_keep <= rd_keep;
         out_last <= rd_last;
         out_user <= rd_user;
      end
   end

endmodule

`default_nettype wire

// ==== logic/pkt_guard_top.sv ====
// ----------------------------------------
// packet guard top: ingress control, word
// memory and credit based egress in one block
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pkt_guard_top #(
   parameter int DATA_BYTE_WID = 8,
   parameter int MAX_PKT_LEN   = 64,
   parameter int USER_WID      = 4,
   parameter bit DROP_ERRORED  = 1'b1,
   parameter int CREDIT_MAX    = 4,
   localparam int ADDR_WID     = pkt_guard_pkg::buf_addr_wid(MAX_PKT_LEN, DATA_BYTE_WID)
) (
   input  logic                       axi4s_in,
   input  logic                       arst_n,
   // source side, never stalled
   input  logic                       in_valid,
   input  logic [DATA_BYTE_WID*8-1:0] in_data,
   input  logic [DATA_BYTE_WID-1:0]   in_keep,
   input  logic                       in_last,
   input  logic [USER_WID-1:0]        in_user,
   // sink side, one credit pulse per free word
   input  logic                       out_credit,
   output logic                       out_valid,
   output logic [DATA_BYTE_WID*8-1:0] out_data,
   output logic [DATA_BYTE_WID-1:0]   out_keep,
   output logic                       out_last,
   output logic [USER_WID-1:0]        out_user,
   // drop status
   output logic                       drop_pulse,
   output pkt_guard_pkg::drop_cause_t drop_cause
);

   // write port
   logic                       wr_en;
   logic [ADDR_WID-1:0]        wr_addr;
   logic [DATA_BYTE_WID*8-1:0] wr_data;
   logic [DATA_BYTE_WID-1:0]   wr_keep;
   logic                       wr_last;
   logic [USER_WID-1:0]        wr_user;
   // read port
   logic                       rd_en;
   logic [ADDR_WID-1:0]        rd_addr;
   logic [DATA_BYTE_WID*8-1:0] rd_data;
   logic [DATA_BYTE_WID-1:0]   rd_keep;
   logic                       rd_last;
   logic [USER_WID-1:0]        rd_user;
   // buffer pointers
   logic [ADDR_WID:0]          sop_ptr;
   logic [ADDR_WID:0]          rd_ptr;

   pkt_ingress #(
      .DATA_BYTE_WID (DATA_BYTE_WID),
      .MAX_PKT_LEN   (MAX_PKT_LEN),
      .USER_WID      (USER_WID),
      .DROP_ERRORED  (DROP_ERRORED)
   ) pkt_ingress_i (
      .axi4s_in   (axi4s_in),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_keep    (in_keep),
      .in_last    (in_last),
      .in_user    (in_user),
      .rd_ptr     (rd_ptr),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wr_keep    (wr_keep),
      .wr_last    (wr_last),
      .wr_user    (wr_user),
      .wr_ptr     (),
      .sop_ptr    (sop_ptr),
      .drop_pulse (drop_pulse),
      .drop_cause (drop_cause)
   );

   pkt_ram #(
      .DATA_BYTE_WID (DATA_BYTE_WID),
      .MAX_PKT_LEN   (MAX_PKT_LEN),
      .USER_WID      (USER_WID)
   ) pkt_ram_i (
      .axi4s_in (axi4s_in),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_keep  (wr_keep),
      .wr_last  (wr_last),
      .wr_user  (wr_user),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .rd_keep  (rd_keep),
      .rd_last  (rd_last),
      .rd_user  (rd_user)
   );

   pkt_egress #(
      .DATA_BYTE_WID (DATA_BYTE_WID),
      .MAX_PKT_LEN   (MAX_PKT_LEN),
      .USER_WID      (USER_WID),
      .CREDIT_MAX    (CREDIT_MAX)
   ) pkt_egress_i (
      .axi4s_in   (axi4s_in),
      .arst_n     (arst_n),
      .sop_ptr    (sop_ptr),
      .out_credit (out_credit),
      .rd_data    (rd_data),
      .rd_keep    (rd_keep),
      .rd_last    (rd_last),
      .rd_user    (rd_user),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .rd_ptr     (rd_ptr),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_keep   (out_keep),
      .out_last   (out_last),
      .out_user   (out_user)
   );

endmodule

`default_nettype wire

// ==== tests/pkt_guard_assert.sv ====
// ----------------------------------------
// credit rules of the egress side, bound
// into every pkt_egress instance
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pkt_guard_assert #(
   parameter int CREDIT_MAX = 4,
   parameter int CNT_WID    = 3
) (
   input logic               axi4s_in,
   input logic               arst_n,
   input logic               rd_en,
   input logic               out_valid,
   input logic               out_credit,
   input logic [CNT_WID-1:0] credit_q
);

   int sent_cnt;
   int ret_cnt;
   int rd_cnt;
   // number of failed assertions
   int assert_fails = 0;

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         sent_cnt <= 0;
         ret_cnt  <= 0;
         rd_cnt   <= 0;
      end else begin
         sent_cnt <= sent_cnt + int'(out_valid);
         ret_cnt  <= ret_cnt + int'(out_credit);
         rd_cnt   <= rd_cnt + int'(rd_en);
      end
   end

   // credits granted minus reads already issued must leave one for this read
   rd_needs_credit: assert property (
      @(posedge axi4s_in) disable iff (!arst_n)
      rd_en |-> (CREDIT_MAX + ret_cnt - rd_cnt > 0)
   ) else begin
      assert_fails++;
      $error("read issued with the credit count at zero");
   end

   // returns never push the count past its reset value
   credit_bounded: assert property (
      @(posedge axi4s_in) disable iff (!arst_n) int'(credit_q) <= CREDIT_MAX
   ) else begin
      assert_fails++;
      $error("credit count above its limit");
   end

   // words out never outrun the credits granted so far
   words_within_credit: assert property (
      @(posedge axi4s_in) disable iff (!arst_n)
      sent_cnt + int'(out_valid) <= CREDIT_MAX + ret_cnt + int'(out_credit)
   ) else begin
      assert_fails++;
      $error("more words sent than credits granted");
   end

endmodule

bind pkt_egress pkt_guard_assert #(
   .CREDIT_MAX (CREDIT_MAX),
   .CNT_WID    (CNT_WID)
) pkt_guard_assert_i (
   .axi4s_in   (axi4s_in),
   .arst_n     (arst_n),
   .rd_en      (rd_en),
   .out_valid  (out_valid),
   .out_credit (out_credit),
   .credit_q   (credit_q)
);

`default_nettype wire

// ==== tests/pkt_guard_checker.sv ====
// ----------------------------------------
// reference model of the packet guard: predicts
// drops, egress timing and every word that leaves
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pkt_guard_checker #(
   parameter int DATA_BYTE_WID = 8,
   parameter int MAX_PKT_LEN   = 64,
   parameter int USER_WID      = 4,
   parameter bit DROP_ERRORED  = 1'b1,
   parameter int CREDIT_MAX    = 4
) (
   input  logic                       axi4s_in,
   input  logic                       arst_n,
   input  logic                       in_valid,
   input  logic [DATA_BYTE_WID*8-1:0] in_data,
   input  logic [DATA_BYTE_WID-1:0]   in_keep,
   input  logic                       in_last,
   input  logic [USER_WID-1:0]        in_user,
   input  logic                       out_credit,
   input  logic                       out_valid,
   input  logic [DATA_BYTE_WID*8-1:0] out_data,
   input  logic [DATA_BYTE_WID-1:0]   out_keep,
   input  logic                       out_last,
   input  logic [USER_WID-1:0]        out_user,
   input  logic                       drop_pulse,
   input  pkt_guard_pkg::drop_cause_t drop_cause,
   output int                         mismatch_cnt,
   output int                         fail_cnt,
   output int                         pending,
   output int                         ovfl_cnt,
   output int                         err_cnt
);
   import pkt_guard_pkg::*;

   localparam int DW       = DATA_BYTE_WID * 8;
   localparam int KW       = DATA_BYTE_WID;
   localparam int WORD_W   = 1 + USER_WID + KW + DW;
   // start refused above two max packets of stored words
   localparam int OVFL_LVL = 2 * ((MAX_PKT_LEN + DATA_BYTE_WID - 1) / DATA_BYTE_WID);

   // word layout {last, user, keep, data}
   logic [WORD_W-1:0] exp_q[$];
   logic [WORD_W-1:0] cur_q[$];
   ing_state_t        m_state;
   // reads in flight towards out_valid
   logic [1:0]        vld_pipe;
   int                released;
   int                reads;
   int                credit;
   int                sent;
   int                returned;

   task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                  input logic [63:0] got_v);
      $display("mismatch %s: expected %h, got %h at %0t", name, exp_v, got_v, $time);
      mismatch_cnt++;
   endtask

   always @(posedge axi4s_in or negedge arst_n) begin : model
      logic              rd_now;
      logic              exp_drop;
      drop_cause_t       exp_cause;
      logic [WORD_W-1:0] w;
      if (!arst_n) begin
         exp_q.delete();
         cur_q.delete();
         m_state  = ING_SOP;
         vld_pipe = 2'b00;
         released = 0;
         reads    = 0;
         credit   = CREDIT_MAX;
         sent     = 0;
         returned = 0;
         pending  = 0;
         mismatch_cnt = 0;
         fail_cnt = 0;
         ovfl_cnt = 0;
         err_cnt  = 0;
      end else begin
         // read and fill judged on state before this edge
         rd_now    = (released != reads) && (credit > 0);
         exp_drop  = 1'b0;
         exp_cause = DROP_NONE;
         if (in_valid) begin
            w = {in_last, in_user, in_keep, in_data};
            if (m_state == ING_DROP || (m_state == ING_SOP && released - reads > OVFL_LVL)) begin
               // overflowed packet, skipped until its last word
               m_state   = in_last ? ING_SOP : ING_DROP;
               exp_drop  = in_last;
               exp_cause = in_last ? DROP_OVFL : DROP_NONE;
            end else if (!in_last) begin
               cur_q.push_back(w);
               m_state = ING_BODY;
            end else if (DROP_ERRORED && in_user[0]) begin
               cur_q.delete();
               m_state   = ING_SOP;
               exp_drop  = 1'b1;
               exp_cause = DROP_ERR;
            end else begin
               // whole packet is in, now it may leave
               cur_q.push_back(w);
               released += cur_q.size();
               while (cur_q.size() > 0) begin
                  exp_q.push_back(cur_q.pop_front());
               end
               m_state = ING_SOP;
            end
         end
         if (drop_pulse !== exp_drop) begin
            report_mismatch("drop_pulse", 64'(exp_drop), 64'(drop_pulse));
         end else if (drop_cause !== exp_cause) begin
            report_mismatch("drop_cause", 64'(exp_cause), 64'(drop_cause));
         end
         if (drop_pulse && drop_cause == DROP_OVFL) ovfl_cnt++;
         if (drop_pulse && drop_cause == DROP_ERR) err_cnt++;
         // ----------------------------------------
         // egress side
         // ----------------------------------------
         if (out_valid !== vld_pipe[1]) begin
            report_mismatch("out_valid", 64'(vld_pipe[1]), 64'(out_valid));
         end
         if (out_valid === 1'b1) begin
            sent++;
            if (exp_q.size() == 0) begin
               $display("failure: a word left with no complete packet pending at %0t", $time);
               fail_cnt++;
            end else begin
               w = exp_q.pop_front();
               if (out_data !== w[DW-1:0]) begin
                  report_mismatch("out_data", 64'(w[DW-1:0]), 64'(out_data));
               end
               if (out_keep !== w[DW+KW-1:DW]) begin
                  report_mismatch("out_keep", 64'(w[DW+KW-1:DW]), 64'(out_keep));
               end
               if (out_user !== w[WORD_W-2:DW+KW]) begin
                  report_mismatch("out_user", 64'(w[WORD_W-2:DW+KW]), 64'(out_user));
               end
               if (out_last !== w[WORD_W-1]) begin
                  report_mismatch("out_last", 64'(w[WORD_W-1]), 64'(out_last));
               end
            end
         end
         if (out_credit) returned++;
         if (sent > CREDIT_MAX + returned) begin
            $display("failure: %0d words sent against %0d credits", sent, CREDIT_MAX + returned);
            fail_cnt++;
         end
         vld_pipe = {vld_pipe[0], rd_now};
         if (rd_now) reads++;
         credit  = credit + int'(out_credit) - int'(rd_now);
         pending = exp_q.size();
      end
   end

endmodule

`default_nettype wire

// ==== tests/pkt_guard_tb.sv ====
// ----------------------------------------
// testbench for the packet guard: random packets
// in three phases, a sink that returns credits,
// a cycle limit and the closing summary
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pkt_guard_tb;
   import pkt_guard_pkg::*;

   localparam int DATA_BYTE_WID = 8;
   localparam int MAX_PKT_LEN   = 64;
   localparam int USER_WID      = 4;
   localparam bit DROP_ERRORED  = 1'b1;
   localparam int CREDIT_MAX    = 4;
   localparam int MAX_WORDS     = (MAX_PKT_LEN + DATA_BYTE_WID - 1) / DATA_BYTE_WID;
   localparam int SEED          = 32'h890b_da74;

   // ----------------------------------------
   // run length
   // ----------------------------------------

   // open traffic, credits withheld, open traffic again
   localparam int PH1_PKTS    = 40;
   localparam int PH2_PKTS    = 6;
   localparam int PH3_PKTS    = 20;
   localparam int HOLD_GAP    = 30;
   localparam int STIM_CYCLES = (PH1_PKTS + PH3_PKTS) * (MAX_WORDS + 3)
                                + PH2_PKTS * MAX_WORDS + HOLD_GAP + 20;
   localparam int TIMEOUT     = 20 * STIM_CYCLES;

   logic                       axi4s_in;
   logic                       arst_n;
   logic                       in_valid;
   logic [DATA_BYTE_WID*8-1:0] in_data;
   logic [DATA_BYTE_WID-1:0]   in_keep;
   logic                       in_last;
   logic [USER_WID-1:0]        in_user;
   logic                       out_credit = 1'b0;
   logic                       out_valid;
   logic [DATA_BYTE_WID*8-1:0] out_data;
   logic [DATA_BYTE_WID-1:0]   out_keep;
   logic                       out_last;
   logic [USER_WID-1:0]        out_user;
   logic                       drop_pulse;
   drop_cause_t                drop_cause;
   // sink state, words taken but not yet credited back
   logic                       hold_credit = 1'b0;
   int                         owed = 0;
   int                         tb_fails = 0;
   int                         cycles;
   int                         mismatch_cnt;
   int                         fail_cnt;
   int                         pending;
   int                         ovfl_cnt;
   int                         err_cnt;

   pkt_guard_top #(
      .DATA_BYTE_WID (DATA_BYTE_WID),
      .MAX_PKT_LEN   (MAX_PKT_LEN),
      .USER_WID      (USER_WID),
      .DROP_ERRORED  (DROP_ERRORED),
      .CREDIT_MAX    (CREDIT_MAX)
   ) pkt_guard_top_i (.*);

   pkt_guard_checker #(
      .DATA_BYTE_WID (DATA_BYTE_WID),
      .MAX_PKT_LEN   (MAX_PKT_LEN),
      .USER_WID      (USER_WID),
      .DROP_ERRORED  (DROP_ERRORED),
      .CREDIT_MAX    (CREDIT_MAX)
   ) pkt_guard_checker_i (.*);

   initial begin
      axi4s_in = 1'b0;
      forever #2 axi4s_in = ~axi4s_in;
   end

   // ----------------------------------------
   // stimulus helpers
   // ----------------------------------------

   // one packet, full keep except on the last word
   task automatic send_pkt(input int words, input bit err);
      int                    i;
      int                    k;
      logic [USER_WID-1:0]   user;
      logic [DATA_BYTE_WID*8-1:0] data;
      for (i = 0; i < words; i++) begin
         data = '0;
         for (k = 0; k < DATA_BYTE_WID * 8; k += 32) begin
            data = (data << 32) | (DATA_BYTE_WID*8)'($urandom);
         end
         user = USER_WID'($urandom);
         @(posedge axi4s_in);
         in_valid <= 1'b1;
         in_data  <= data;
         in_last  <= (i == words - 1);
         if (i == words - 1) begin
            // error flag only means something here
            user[0] = err;
            in_keep <= {DATA_BYTE_WID{1'b1}} >> ($urandom % DATA_BYTE_WID);
         end else begin
            in_keep <= '1;
         end
         in_user <= user;
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge axi4s_in);
         in_valid <= 1'b0;
         in_last  <= 1'b0;
      end
   endtask

   // sink returns one credit per word taken unless held back
   always @(posedge axi4s_in) begin
      if (out_valid === 1'b1) begin
         owed = owed + 1;
      end
      if (!hold_credit && owed > 0) begin
         out_credit <= 1'b1;
         owed = owed - 1;
      end else begin
         out_credit <= 1'b0;
      end
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin : stimulus
      int i;
      int total;
      void'($urandom(SEED));
      arst_n   = 1'b0;
      in_valid = 1'b0;
      in_data  = '0;
      in_keep  = '0;
      in_last  = 1'b0;
      in_user  = '0;
      repeat (3) @(posedge axi4s_in);
      arst_n <= 1'b1;
      // quiet stretch, no word and no drop expected
      idle(8);
      for (i = 0; i < PH1_PKTS; i++) begin
         send_pkt(1 + $urandom % MAX_WORDS, ($urandom % 5) == 0);
         idle($urandom % 4);
      end
      // sink stalls, buffer fills and later starts get refused
      hold_credit <= 1'b1;
      for (i = 0; i < PH2_PKTS; i++) begin
         send_pkt(MAX_WORDS, 1'b0);
      end
      idle(HOLD_GAP);
      hold_credit <= 1'b0;
      for (i = 0; i < PH3_PKTS; i++) begin
         send_pkt(1 + $urandom % MAX_WORDS, ($urandom % 5) == 0);
         idle($urandom % 4);
      end
      idle(1);
      // drain, the cycle limit catches a buffer that never empties
      while (pending != 0 || owed != 0) begin
         @(negedge axi4s_in);
      end
      idle(10);
      if (ovfl_cnt == 0) begin
         $display("failure: no overflow drop happened while credits were held");
         tb_fails++;
      end
      if (err_cnt == 0) begin
         $display("failure: no errored packet was dropped");
         tb_fails++;
      end
      total = mismatch_cnt + fail_cnt + tb_fails
              + pkt_guard_top_i.pkt_egress_i.pkt_guard_assert_i.assert_fails;
      $display("summary: %0d mismatches, %0d other failures, %0d ovfl drops, %0d err drops",
               mismatch_cnt, total - mismatch_cnt, ovfl_cnt, err_cnt);
      if (total == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // run limit
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT) begin
         @(posedge axi4s_in);
         cycles++;
      end
      $display("failure: the run did not finish within %0d cycles", TIMEOUT);
      $display("summary: %0d mismatches, %0d other failures", mismatch_cnt,
               fail_cnt + tb_fails + 1);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/pkt_guard_pkg.sv
logic/pkt_ingress.sv
logic/pkt_ram.sv
logic/pkt_egress.sv
logic/pkt_guard_top.sv
tests/pkt_guard_assert.sv
tests/pkt_guard_checker.sv
tests/pkt_guard_tb.sv

// ==== Makefile ====
# Verilator flow for the packet guard
TOP := pkt_guard_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wall -f sim.f --top-module pkt_guard_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
